// File: design/prefetch_pkg.sv
/*
  Shared types and constants of the instruction prefetch buffer.
  Addresses and instructions are 32 bits and every fetch is word aligned.
  QUEUE_DEPTH must be at least 2 so that one response can still land
  after the controller has stopped issuing sequential requests.
*/

package prefetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // data widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned ADDR_W  = 32;
  localparam int unsigned INSTR_W = 32;

  // byte address on the fetch port
  typedef logic [ADDR_W-1:0] addr_t;
  // one fetched instruction word
  typedef logic [INSTR_W-1:0] instr_t;

  // distance in bytes between two sequential instruction words
  localparam addr_t FETCH_STEP = addr_t'(4);

  ////////////////////////////////////////////////////////////////////////////
  // instruction queue
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned QUEUE_DEPTH = 2;
  localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

  // the count has to reach QUEUE_DEPTH itself so it gets one extra value
  typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_cnt_t;
  typedef logic [QUEUE_PTR_W-1:0] queue_ptr_t;

  // no new sequential request goes out at or above this occupancy
  localparam queue_cnt_t QUEUE_ALM_FULL = queue_cnt_t'(QUEUE_DEPTH - 1);
  // highest slot index before the pointers wrap around
  localparam queue_ptr_t QUEUE_LAST = queue_ptr_t'(QUEUE_DEPTH - 1);

  ////////////////////////////////////////////////////////////////////////////
  // fetch controller states
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    FS_IDLE,
    FS_WAIT_GNT,
    FS_WAIT_RVALID,
    FS_WAIT_ABORTED,
    FS_WAIT_JUMP
  } fetch_state_e;

endpackage

// File: design/instr_queue_if.sv
/*
  Link between the fetch controller and the instruction queue.
  The response word and its valid are driven from outside both modports
  straight from the memory port. The controller only decides what happens
  to that word and the queue reports its own status back.
*/

`timescale 1ns/1ps

interface instr_queue_if;

  // response of the instruction memory in the current cycle
  logic                 resp_valid;
  prefetch_pkg::instr_t resp_data;

  // store the current response word instead of passing it on
  logic                 resp_push;
  // empty the queue at the next edge and win over a push
  logic                 resp_flush;

  // queue status as seen by the controller
  logic                 q_not_empty;
  logic                 q_has_space;
  // head word leaves the queue in this cycle
  logic                 q_pop;

  // the controller never needs the data word itself
  modport ctrl (
    input  resp_valid,
    input  q_not_empty,
    input  q_has_space,
    output resp_push,
    output resp_flush
  );

  modport queue (
    input  resp_valid,
    input  resp_data,
    input  resp_push,
    input  resp_flush,
    output q_not_empty,
    output q_has_space,
    output q_pop
  );

endinterface

// File: design/fetch_ctrl.sv
/*
  Fetch state machine of the prefetch buffer. Mealy style so requests,
  pushes and flushes are combinational in the cycle of their cause.
  Only one memory request is ever outstanding. A branch while a response
  is still in flight waits for that stale response and drops it.
  A protection fault stops fetching until the next branch.
  The branch pulse is expected only while req_i is high.
*/

`timescale 1ns/1ps

module fetch_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_i,
  input  logic                branch_i,
  input  prefetch_pkg::addr_t addr_i,
  input  logic                ready_i,
  input  logic                instr_gnt_i,
  input  logic                instr_err_pmp_i,
  input  logic                valid_i,
  output logic                instr_req_o,
  output prefetch_pkg::addr_t instr_addr_o,
  output logic                fetch_failed_o,
  output logic                busy_o,
  output logic                out_allowed_o,
  instr_queue_if.ctrl         q_if
);

  prefetch_pkg::fetch_state_e state_q;
  prefetch_pkg::fetch_state_e state_d;
  // state that follows once a request is put on the bus
  prefetch_pkg::fetch_state_e issue_state;

  // address of the last request that went out
  prefetch_pkg::addr_t addr_q;
  prefetch_pkg::addr_t next_seq_addr;
  logic                addr_upd;

  // a response has to be kept when the core cannot take it right now
  logic                keep_resp;

  ////////////////////////////////////////////////////////////////////////////
  // address and status
  ////////////////////////////////////////////////////////////////////////////

  // drop the byte offset of the last address and step to the next word
  assign next_seq_addr = {addr_q[prefetch_pkg::ADDR_W-1:2], 2'b00} + prefetch_pkg::FETCH_STEP;

  // older words still wait in the queue or the core is stalled
  assign keep_resp = q_if.q_not_empty | ~ready_i;

  // a faulting request is never granted so the fault wins over the grant
  assign issue_state = instr_err_pmp_i ? prefetch_pkg::FS_WAIT_JUMP :
                       instr_gnt_i     ? prefetch_pkg::FS_WAIT_RVALID :
                                         prefetch_pkg::FS_WAIT_GNT;

  assign busy_o = (state_q != prefetch_pkg::FS_IDLE) || instr_req_o;

  // the stale response of an aborted fetch must not reach the core
  assign out_allowed_o = (state_q != prefetch_pkg::FS_WAIT_ABORTED);

  ////////////////////////////////////////////////////////////////////////////
  // next state and memory port
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    instr_req_o     = 1'b0;
    instr_addr_o    = next_seq_addr;
    addr_upd        = 1'b0;
    fetch_failed_o  = 1'b0;
    q_if.resp_push  = 1'b0;
    q_if.resp_flush = 1'b0;

    unique case (state_q)
      // nothing outstanding
      prefetch_pkg::FS_IDLE: begin
        if (branch_i) begin
          instr_addr_o = addr_i;
        end
        // a branch always goes out since the queue is flushed with it
        if (req_i && (q_if.q_has_space || branch_i)) begin
          instr_req_o = 1'b1;
          addr_upd    = 1'b1;
          state_d     = issue_state;
        end
      end

      // request is on the bus and holds until granted
      prefetch_pkg::FS_WAIT_GNT: begin
        instr_req_o  = 1'b1;
        instr_addr_o = addr_q;
        // nothing was granted yet so the request simply changes target
        if (branch_i) begin
          instr_addr_o = addr_i;
          addr_upd     = 1'b1;
        end
        state_d = issue_state;
      end

      // granted and waiting for the response
      prefetch_pkg::FS_WAIT_RVALID: begin
        if (branch_i) begin
          instr_addr_o = addr_i;
        end
        if (req_i && (q_if.q_has_space || branch_i)) begin
          if (q_if.resp_valid) begin
            // response and next request share this cycle
            instr_req_o    = 1'b1;
            addr_upd       = 1'b1;
            q_if.resp_push = keep_resp;
            state_d        = issue_state;
          end else if (branch_i) begin
            // the word in flight now belongs to the old stream
            addr_upd = 1'b1;
            state_d  = prefetch_pkg::FS_WAIT_ABORTED;
          end
        end else if (q_if.resp_valid) begin
          // no room or no demand so take the word and rest
          q_if.resp_push = keep_resp;
          state_d        = prefetch_pkg::FS_IDLE;
        end
      end

      // the branch target was saved and the stale response is still due
      prefetch_pkg::FS_WAIT_ABORTED: begin
        instr_addr_o = addr_q;
        if (branch_i) begin
          instr_addr_o = addr_i;
          addr_upd     = 1'b1;
        end
        if (q_if.resp_valid) begin
          // stale word is thrown away and the target goes out at once
          q_if.resp_flush = 1'b1;
          instr_req_o     = 1'b1;
          state_d         = issue_state;
        end
      end

      // fetching stopped on a fault and only a branch restarts it
      prefetch_pkg::FS_WAIT_JUMP: begin
        // the core sees the failure once the good words are gone
        fetch_failed_o = ~valid_i;
        if (branch_i) begin
          fetch_failed_o = 1'b0;
          instr_addr_o   = addr_i;
          instr_req_o    = 1'b1;
          addr_upd       = 1'b1;
          state_d        = issue_state;
        end
      end

      default: begin
        state_d = prefetch_pkg::FS_IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= prefetch_pkg::FS_IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      // keep whatever address was issued or saved as branch target
      if (addr_upd) begin
        addr_q <= instr_addr_o;
      end
    end
  end

endmodule

// File: design/instr_queue.sv
/*
  Small circular buffer for fetched instruction words.
  An empty queue passes the memory response straight to the core
  unless the controller hides it. A stored word shows up at the output
  one cycle after its push. Pushes above QUEUE_DEPTH are not checked here
  because the controller limits the words in flight.
*/

`timescale 1ns/1ps

module instr_queue (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ready_i,
  input  logic                 out_allowed_i,
  input  logic                 branch_i,
  instr_queue_if.queue         q_if,
  output logic                 valid_o,
  output prefetch_pkg::instr_t rdata_o
);

  prefetch_pkg::instr_t     mem_q [prefetch_pkg::QUEUE_DEPTH];
  prefetch_pkg::queue_ptr_t rd_ptr_q;
  prefetch_pkg::queue_ptr_t wr_ptr_q;
  prefetch_pkg::queue_cnt_t cnt_q;

  logic flush;
  logic push;
  logic pop;

  // step a pointer and wrap it after the last slot
  function automatic prefetch_pkg::queue_ptr_t ptr_inc(
    input prefetch_pkg::queue_ptr_t ptr
  );
    if (ptr == prefetch_pkg::QUEUE_LAST) begin
      return '0;
    end
    return ptr + prefetch_pkg::queue_ptr_t'(1);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // status and control
  ////////////////////////////////////////////////////////////////////////////

  // a branch empties the queue just like a flush from the controller
  assign flush = q_if.resp_flush | branch_i;
  assign push  = q_if.resp_push & q_if.resp_valid & ~flush;
  assign pop   = q_if.q_pop;

  assign q_if.q_not_empty = (cnt_q != '0);
  assign q_if.q_has_space = (cnt_q < prefetch_pkg::QUEUE_ALM_FULL);
  // the head leaves whenever the core accepts it
  assign q_if.q_pop       = q_if.q_not_empty & ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // a push and a pop together leave the count alone
      if (push && !pop) begin
        cnt_q <= cnt_q + prefetch_pkg::queue_cnt_t'(1);
      end else if (!push && pop) begin
        cnt_q <= cnt_q - prefetch_pkg::queue_cnt_t'(1);
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= q_if.resp_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output towards the core
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (q_if.q_not_empty) begin
      valid_o = 1'b1;
      rdata_o = mem_q[rd_ptr_q];
    end else begin
      // bypass with the data held at zero while no response is there
      valid_o = q_if.resp_valid & out_allowed_i;
      rdata_o = q_if.resp_data & {prefetch_pkg::INSTR_W{q_if.resp_valid}};
    end
  end

endmodule

// File: design/prefetch_buffer.sv
/*
  Instruction prefetch buffer between the core fetch stage and the
  instruction memory port. The memory side uses request and grant with
  a separate response valid. The core side uses valid and ready.
  While the queue is empty valid_o may follow instr_rvalid_i and fall
  again without a transfer. That word is then already in the queue.
*/

`timescale 1ns/1ps

module prefetch_buffer (
  input  logic                 clk,
  input  logic                 rst_n,

  // core fetch stage
  input  logic                 req_i,
  input  logic                 branch_i,
  input  prefetch_pkg::addr_t  addr_i,
  input  logic                 ready_i,
  output logic                 valid_o,
  output prefetch_pkg::instr_t rdata_o,

  // instruction memory port
  output logic                 instr_req_o,
  input  logic                 instr_gnt_i,
  output prefetch_pkg::addr_t  instr_addr_o,
  input  prefetch_pkg::instr_t instr_rdata_i,
  input  logic                 instr_rvalid_i,
  input  logic                 instr_err_pmp_i,

  // status
  output logic                 fetch_failed_o,
  output logic                 busy_o
);

  // low while the controller waits for a response it has abandoned
  logic out_allowed;

  instr_queue_if q_if ();

  // the response path reaches the queue without any register
  assign q_if.resp_valid = instr_rvalid_i;
  assign q_if.resp_data  = instr_rdata_i;

  ////////////////////////////////////////////////////////////////////////////
  // fetch controller
  ////////////////////////////////////////////////////////////////////////////

  fetch_ctrl fetch_ctrl_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req_i),
    .branch_i        (branch_i),
    .addr_i          (addr_i),
    .ready_i         (ready_i),
    .instr_gnt_i     (instr_gnt_i),
    .instr_err_pmp_i (instr_err_pmp_i),
    .valid_i         (valid_o),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .fetch_failed_o  (fetch_failed_o),
    .busy_o          (busy_o),
    .out_allowed_o   (out_allowed),
    .q_if            (q_if.ctrl)
  );

  ////////////////////////////////////////////////////////////////////////////
  // instruction queue
  ////////////////////////////////////////////////////////////////////////////

  instr_queue instr_queue_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .ready_i       (ready_i),
    .out_allowed_i (out_allowed),
    .branch_i      (branch_i),
    .q_if          (q_if.queue),
    .valid_o       (valid_o),
    .rdata_o       (rdata_o)
  );

endmodule

// File: test/instr_mem_model.sv
/*
  Reactive instruction memory for the prefetch buffer testbench.
  Grants after a random number of cycles and answers 1 to 3 cycles
  after the grant. The word of an address is its bitwise inverse.
  Addresses in the protected window raise the fault and are never granted.
*/

`timescale 1ns/1ps

module instr_mem_model #(
  parameter logic [31:0] PMP_LO = 32'h0000_8000,
  parameter logic [31:0] PMP_HI = 32'h0000_80ff,
  parameter logic [31:0] SEED   = 32'd19686
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_pmp_o
);

  logic [31:0] seed_q;
  logic [31:0] addr_q;
  logic [1:0]  wait_q;
  logic [1:0]  lat;
  logic        gnt_q;
  logic        accept;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // the fault is seen in the very cycle the request goes out
  assign err_pmp_o = req_i && (addr_i >= PMP_LO) && (addr_i <= PMP_HI);
  // a faulting request never sees the grant
  assign gnt_o     = gnt_q & ~err_pmp_o;
  assign accept    = req_i && gnt_o;
  assign lat       = 2'd1 + 2'(seed_q[23:20] % 4'd3);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seed_q   <= SEED;
      addr_q   <= '0;
      wait_q   <= '0;
      gnt_q    <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      seed_q   <= lcg_step(seed_q);
      // grant is high in about three cycles out of four
      gnt_q    <= (seed_q[17:16] != 2'b00);
      rvalid_o <= 1'b0;
      if (wait_q != 2'd0) begin
        wait_q <= wait_q - 2'd1;
        if (wait_q == 2'd1) begin
          rvalid_o <= 1'b1;
          rdata_o  <= ~addr_q;
        end
      end
      // only one request is outstanding so this never meets a countdown
      if (accept) begin
        addr_q <= addr_i;
        if (lat == 2'd1) begin
          rvalid_o <= 1'b1;
          rdata_o  <= ~addr_i;
        end else begin
          wait_q <= lat - 2'd1;
        end
      end
    end
  end

endmodule

// File: test/tb_prefetch_buffer.sv
/*
  Testbench of the instruction prefetch buffer. Checks the delivered
  word stream against addresses tracked from branches, with stalls,
  random branches and a run into the protected window of the memory.
*/

`timescale 1ns/1ps

module tb_prefetch_buffer;

  localparam logic [31:0] PMP_LO = 32'h0000_8000;
  localparam logic [31:0] PMP_HI = 32'h0000_80ff;
  localparam int PLANNED_XFERS = 264;
  localparam int CYCLE_LIMIT   = 20 * PLANNED_XFERS;

  logic clk = 1'b0;
  logic rst_n, req_i, branch_i, ready_i, valid_o, fetch_failed_o, busy_o;
  logic [31:0] addr_i, rdata_o, instr_addr_o, instr_rdata_i;
  logic instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_pmp_i;

  logic [31:0] seed = 32'd19686;
  logic [31:0] exp_addr = '0;
  // a granted memory request whose response has not been seen yet
  logic mem_pending = 1'b0;
  int xfer_cnt = 0;
  int stream_cnt = 0;
  int cycle_cnt = 0;
  int mismatch_cnt = 0;
  int chk_err_cnt = 0;
  int seq_err_cnt = 0;

  always #20 clk = ~clk;

  prefetch_buffer prefetch_buffer_inst (
    .clk (clk), .rst_n (rst_n), .req_i (req_i), .branch_i (branch_i),
    .addr_i (addr_i), .ready_i (ready_i), .valid_o (valid_o), .rdata_o (rdata_o),
    .instr_req_o (instr_req_o), .instr_gnt_i (instr_gnt_i),
    .instr_addr_o (instr_addr_o), .instr_rdata_i (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i), .instr_err_pmp_i (instr_err_pmp_i),
    .fetch_failed_o (fetch_failed_o), .busy_o (busy_o)
  );

  instr_mem_model #(.PMP_LO (PMP_LO), .PMP_HI (PMP_HI)) mem_inst (
    .clk (clk), .rst_n (rst_n), .req_i (instr_req_o), .addr_i (instr_addr_o),
    .gnt_o (instr_gnt_i), .rvalid_o (instr_rvalid_i), .rdata_o (instr_rdata_i),
    .err_pmp_o (instr_err_pmp_i)
  );

  // the memory holds the inverse of every address
  function automatic logic [31:0] exp_word(input logic [31:0] addr);
    return ~addr;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic draw(output logic [15:0] r);
    seed = lcg_next(seed);
    r = seed[31:16];
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checking and timeout
  ////////////////////////////////////////////////////////////////////////////

  // a transfer in a branch cycle still belongs to the old stream
  always @(posedge clk) begin
    if (rst_n) begin
      if (valid_o && ready_i) begin
        assert (rdata_o == exp_word(exp_addr)) else begin
          $display("mismatch rdata_o: expected %h, got %h", exp_word(exp_addr), rdata_o);
          mismatch_cnt <= mismatch_cnt + 1;
        end
        assert (exp_addr < PMP_LO || exp_addr > PMP_HI) else begin
          $display("a word from the protected window reached the core");
          chk_err_cnt <= chk_err_cnt + 1;
        end
        xfer_cnt   <= xfer_cnt + 1;
        stream_cnt <= stream_cnt + 1;
        exp_addr   <= exp_addr + 32'd4;
      end
      if (branch_i) begin
        exp_addr   <= addr_i;
        stream_cnt <= 0;
      end
      // the buffer is busy while a memory access is under way
      assert (busy_o || !(instr_req_o || mem_pending)) else begin
        $display("busy_o is low while a memory access is under way");
        chk_err_cnt <= chk_err_cnt + 1;
      end
      if (instr_rvalid_i) begin
        mem_pending <= 1'b0;
      end
      if (instr_req_o && instr_gnt_i) begin
        mem_pending <= 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles with %0d transfers", cycle_cnt, xfer_cnt);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // ready mode 0 keeps ready high, 1 drops it half the time, 2 a quarter
  task automatic run_phase(input int n, input int ready_mode, input bit branches);
    logic [15:0] r;
    int goal;
    goal = xfer_cnt + n;
    while (xfer_cnt < goal) begin
      @(posedge clk);
      draw(r);
      ready_i <= (ready_mode == 0) ? 1'b1 : (ready_mode == 1) ? r[15] : (r[14:13] != 2'b00);
      if (branches && r[2:0] == 3'd0) begin
        branch_i <= 1'b1;
        addr_i   <= 32'h0000_2000 + {18'd0, r[11:0], 2'b00};
      end else begin
        branch_i <= 1'b0;
      end
      assert (!fetch_failed_o) else begin
        $display("fetch_failed_o is high during normal fetching");
        seq_err_cnt++;
      end
    end
    @(posedge clk);
    branch_i <= 1'b0;
  endtask

  task automatic jump_to(input logic [31:0] target);
    @(posedge clk);
    ready_i  <= 1'b1;
    branch_i <= 1'b1;
    addr_i   <= target;
    @(posedge clk);
    branch_i <= 1'b0;
  endtask

  initial begin
    rst_n    = 1'b0;
    req_i    = 1'b0;
    branch_i = 1'b0;
    ready_i  = 1'b1;
    addr_i   = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // idle after reset with no demand from the core
    repeat (4) begin
      @(posedge clk);
      assert (!busy_o && !instr_req_o && !fetch_failed_o && !valid_o) else begin
        $display("outputs are not idle after reset");
        seq_err_cnt++;
      end
    end

    // start the stream at the first branch target
    @(posedge clk);
    req_i    <= 1'b1;
    branch_i <= 1'b1;
    addr_i   <= 32'h0000_1000;
    run_phase(40, 0, 1'b0);
    run_phase(60, 1, 1'b0);
    run_phase(150, 2, 1'b1);

    // four good words and then the fault
    jump_to(PMP_LO - 32'd16);
    while (!fetch_failed_o) begin
      @(posedge clk);
    end
    assert (stream_cnt == 4) else begin
      $display("expected 4 words before the protected window, saw %0d", stream_cnt);
      seq_err_cnt++;
    end
    repeat (10) begin
      @(posedge clk);
      assert (fetch_failed_o && !valid_o && busy_o) else begin
        $display("fetch_failed_o or busy_o fell or valid_o rose before the next branch");
        seq_err_cnt++;
      end
    end

    // a branch clears the failure and fetching goes on at the target
    jump_to(32'h0000_3000);
    run_phase(10, 0, 1'b0);
    @(negedge clk);

    $display("summary: %0d transfers, %0d mismatches, %0d other errors",
             xfer_cnt, mismatch_cnt, chk_err_cnt + seq_err_cnt);
    if (mismatch_cnt + chk_err_cnt + seq_err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
design/prefetch_pkg.sv
design/instr_queue_if.sv
design/fetch_ctrl.sv
design/instr_queue.sv
design/prefetch_buffer.sv
test/instr_mem_model.sv
test/tb_prefetch_buffer.sv

// File: run_sim.sh
#!/bin/sh
# builds the prefetch buffer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
  --top-module tb_prefetch_buffer -o sim_prefetch
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_prefetch > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
  exit 0
fi
exit 1
